/* Makefile */
# Verilator build and run of the scheduling path testbench

TOP := tb_pspin_sched

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -Wno-fatal --top-module $(TOP) -f src.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TB PASSED" sim.log; then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* include/pspin_sched_params.svh */
// -------------------------------------------------------------------------
// Build constants for the packet scheduling path
// Cluster indices are $clog2(PSPIN_NUM_CLUSTERS) bits wide, so at least
// two clusters are required. The L1 span must be large enough that the
// last cluster's window stays inside the 32-bit SoC address space.
// -------------------------------------------------------------------------
`ifndef PSPIN_SCHED_PARAMS_SVH
`define PSPIN_SCHED_PARAMS_SVH

// Cluster array
`define PSPIN_NUM_CLUSTERS      4

// Handler slots per cluster, one credit each
`define PSPIN_HERS_PER_CLUSTER  4

// Queue depths
`define PSPIN_HER_FIFO_DEPTH    8
`define PSPIN_FB_FIFO_DEPTH     4

// Cluster L1 address map
`define PSPIN_L1_CLUSTER_BASE   32'h1000_0000
`define PSPIN_L1_CLUSTER_SPAN   32'h0040_0000

`endif

/* src.f */
+incdir+include
src/pspin_sched_pkg.sv
src/desc_fifo.sv
src/sched_cfg_regs.sv
src/cluster_credit_sched.sv
src/pspin_sched_top.sv
tb/tb_clk_gen.sv
tb/tb_pspin_sched.sv

/* src/cluster_credit_sched.sv */
// -------------------------------------------------------------------------
// Credit-based dispatch of HERs to clusters, plus feedback arbitration
// Clusters have no ready: a task is only sent while a credit is held for
// that cluster. At most one task issued and one feedback taken per cycle.
// Task outputs are registered; feedback grants are combinational and are
// withheld while the feedback queue is full.
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`include "pspin_sched_params.svh"

module cluster_credit_sched
  import pspin_sched_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,

  // HER queue head
  input  logic                                       her_valid_i,
  input  her_descr_t                                 her_i,
  output logic                                       her_pop_o,

  input  cluster_mask_t                              enable_i,

  // To clusters
  output cluster_mask_t                              task_valid_o,
  output handler_task_t                              task_o,

  // From clusters
  input  cluster_mask_t                              fb_valid_i,
  input  feedback_descr_t [`PSPIN_NUM_CLUSTERS-1:0]  fb_i,
  output cluster_mask_t                              fb_ready_o,

  // Feedback queue
  output logic                                       fb_push_o,
  output feedback_descr_t                            fb_data_o,
  input  logic                                       fb_full_i
);

  localparam int unsigned NC          = `PSPIN_NUM_CLUSTERS;
  localparam int unsigned MAX_CREDITS = `PSPIN_HERS_PER_CLUSTER;
  localparam int unsigned CRED_W      = $clog2(MAX_CREDITS + 1);

  typedef logic [CRED_W-1:0] credit_t;

  typedef struct packed {
    logic         found;
    cluster_idx_t idx;
  } rr_pick_t;

  credit_t       credit_q [NC];
  cluster_mask_t has_credit, eligible, take, give;
  cluster_idx_t  disp_last_q, fb_last_q;
  rr_pick_t      disp_pick, fb_pick;
  cluster_mask_t task_valid_q;
  handler_task_t task_q;

  // First requester after the last one served, wrapping around
  function automatic rr_pick_t rr_pick(input cluster_mask_t req, input cluster_idx_t last);
    rr_pick_t    pick;
    int unsigned cand;
    pick = '0;
    for (int unsigned off = 1; off <= NC; off++) begin
      cand = (int'(last) + off) % NC;
      if (!pick.found && req[cand]) begin
        pick.found = 1'b1;
        pick.idx   = cluster_idx_t'(cand);
      end
    end
    return pick;
  endfunction

  always_comb begin
    for (int i = 0; i < NC; i++) begin
      has_credit[i] = (credit_q[i] != '0);
    end
    eligible  = enable_i & has_credit;
    disp_pick = rr_pick(eligible, disp_last_q);
    her_pop_o = her_valid_i & disp_pick.found;
    take      = '0;
    if (her_pop_o) take[disp_pick.idx] = 1'b1;

    // Feedback side, held off while the queue toward the NIC is full
    fb_pick = rr_pick(fb_valid_i, fb_last_q);
    give    = '0;
    if (fb_pick.found && !fb_full_i) give[fb_pick.idx] = 1'b1;
  end

  assign fb_ready_o = give;
  assign fb_push_o  = |give;
  assign fb_data_o  = fb_i[fb_pick.idx];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NC; i++) begin
        credit_q[i] <= CRED_W'(MAX_CREDITS);
      end
      // Start just before cluster 0
      disp_last_q  <= cluster_idx_t'(NC - 1);
      fb_last_q    <= cluster_idx_t'(NC - 1);
      task_valid_q <= '0;
    end else begin
      for (int i = 0; i < NC; i++) begin
        case ({take[i], give[i]})
          2'b10:   credit_q[i] <= credit_q[i] - 1'b1;
          2'b01:   credit_q[i] <= credit_q[i] + 1'b1;
          default: credit_q[i] <= credit_q[i];
        endcase
      end
      if (her_pop_o) disp_last_q <= disp_pick.idx;
      if (fb_push_o) fb_last_q   <= fb_pick.idx;
      task_valid_q <= take;
    end
  end

  // Task payload, stamped with the target cluster's L1 window
  always_ff @(posedge clk_i) begin
    if (her_pop_o) begin
      task_q.her_descr  <= her_i;
      task_q.cluster_id <= disp_pick.idx;
      task_q.l1_base    <= `PSPIN_L1_CLUSTER_BASE
                           + addr_t'(disp_pick.idx) * `PSPIN_L1_CLUSTER_SPAN;
    end
  end

  assign task_valid_o = task_valid_q;
  assign task_o       = task_q;

  for (genvar i = 0; i < NC; i++) begin : gen_credit_chk
    a_credit_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_q[i] <= CRED_W'(MAX_CREDITS))
      else $error("cluster %0d credit count out of range", i);

    // Feedback only from a cluster holding an outstanding task
    a_fb_outstanding : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      give[i] |-> (credit_q[i] < CRED_W'(MAX_CREDITS)))
      else $error("cluster %0d returned feedback with no task outstanding", i);
  end

  a_task_enabled : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (task_valid_o & ~$past(enable_i)) == '0)
    else $error("task dispatched to a disabled cluster");

endmodule

/* src/desc_fifo.sv */
// -------------------------------------------------------------------------
// First-word-fall-through descriptor queue
// A push shows at the head one cycle later. Push and pop may share a
// cycle. full_o is high during reset so producers hold off until the
// queue is out of reset. Pushes while full and pops while empty are
// illegal and are ignored.
// -------------------------------------------------------------------------
`timescale 1ns/1ns

module desc_fifo #(
  parameter type         item_t = logic,
  parameter int unsigned DEPTH  = 4
) (
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  push_i,
  input  item_t push_data_i,
  output logic  full_o,

  output logic  valid_o,
  output item_t data_o,
  input  logic  pop_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  item_t            mem_q [DEPTH];
  logic [PTR_W-1:0] head_q, tail_q;
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic             full_q;
  logic             push_en, pop_en;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push_en = push_i & ~full_q;
  assign pop_en  = pop_i & (cnt_q != '0);

  always_comb begin
    cnt_d = cnt_q;
    if (push_en && !pop_en) begin
      cnt_d = cnt_q + 1'b1;
    end else if (pop_en && !push_en) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
      full_q <= 1'b1;
    end else begin
      if (push_en) tail_q <= next_ptr(tail_q);
      if (pop_en)  head_q <= next_ptr(head_q);
      cnt_q  <= cnt_d;
      full_q <= (cnt_d == CNT_W'(DEPTH));
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_en) mem_q[tail_q] <= push_data_i;
  end

  assign full_o  = full_q;
  assign valid_o = (cnt_q != '0);
  assign data_o  = mem_q[head_q];

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o)
    else $error("desc_fifo: push while full");

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> valid_o)
    else $error("desc_fifo: pop while empty");

endmodule

/* src/pspin_sched_pkg.sv */
// -------------------------------------------------------------------------
// Descriptor types shared by the scheduling path
// Field order of the packed structs is part of the NIC and cluster port
// layout, so changing it changes the bit positions seen at the top level.
// -------------------------------------------------------------------------
`include "pspin_sched_params.svh"

package pspin_sched_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [9:0]  msgid_t;

  typedef logic [`PSPIN_NUM_CLUSTERS-1:0]         cluster_mask_t;
  typedef logic [$clog2(`PSPIN_NUM_CLUSTERS)-1:0] cluster_idx_t;

  // Handler execution request from the NIC inbound engine
  typedef struct packed {
    msgid_t      msgid;
    addr_t       handler_addr;
    addr_t       pkt_addr;
    logic [15:0] pkt_size;
  } her_descr_t;

  // HER stamped with its target cluster
  typedef struct packed {
    her_descr_t   her_descr;
    cluster_idx_t cluster_id;
    addr_t        l1_base;
  } handler_task_t;

  // Completion notice back to the NIC
  typedef struct packed {
    msgid_t      msgid;
    addr_t       pkt_addr;
    logic [15:0] pkt_size;
  } feedback_descr_t;

endpackage

/* src/pspin_sched_top.sv */
// -------------------------------------------------------------------------
// Packet scheduling path top level
// HERs enter on valid/ready, wait in a single in-order queue and are sent
// to enabled clusters under per-cluster credits. Clusters must accept
// every task they are sent. Feedback is queued toward the NIC, and NIC
// back-pressure eventually stalls dispatch and drops her_ready_o.
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`include "pspin_sched_params.svh"

module pspin_sched_top
  import pspin_sched_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,

  // From NIC inbound
  input  logic                                       her_valid_i,
  output logic                                       her_ready_o,
  input  her_descr_t                                 her_i,

  // To clusters
  output cluster_mask_t                              cluster_task_valid_o,
  output handler_task_t                              cluster_task_o,

  // From clusters
  input  cluster_mask_t                              cluster_feedback_valid_i,
  output cluster_mask_t                              cluster_feedback_ready_o,
  input  feedback_descr_t [`PSPIN_NUM_CLUSTERS-1:0]  cluster_feedback_i,

  // To NIC inbound
  output logic                                       nic_feedback_valid_o,
  input  logic                                       nic_feedback_ready_i,
  output feedback_descr_t                            nic_feedback_o,

  // Configuration
  input  logic                                       cfg_we_i,
  input  cluster_mask_t                              cfg_enable_i,
  output logic                                       pspin_active_o
);

  logic            her_full, her_push;
  logic            her_head_valid, her_pop;
  her_descr_t      her_head;
  logic            fb_push, fb_full, fb_pop;
  feedback_descr_t fb_push_data;
  cluster_mask_t   cluster_enable;

  assign her_ready_o = ~her_full;
  assign her_push    = her_valid_i & her_ready_o;
  assign fb_pop      = nic_feedback_valid_o & nic_feedback_ready_i;

  // HER queue
  desc_fifo #(
    .item_t      (her_descr_t),
    .DEPTH       (`PSPIN_HER_FIFO_DEPTH)
  ) i_her_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (her_push),
    .push_data_i (her_i),
    .full_o      (her_full),
    .valid_o     (her_head_valid),
    .data_o      (her_head),
    .pop_i       (her_pop)
  );

  cluster_credit_sched i_sched (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .her_valid_i  (her_head_valid),
    .her_i        (her_head),
    .her_pop_o    (her_pop),
    .enable_i     (cluster_enable),
    .task_valid_o (cluster_task_valid_o),
    .task_o       (cluster_task_o),
    .fb_valid_i   (cluster_feedback_valid_i),
    .fb_i         (cluster_feedback_i),
    .fb_ready_o   (cluster_feedback_ready_o),
    .fb_push_o    (fb_push),
    .fb_data_o    (fb_push_data),
    .fb_full_i    (fb_full)
  );

  // Feedback queue toward the NIC
  desc_fifo #(
    .item_t      (feedback_descr_t),
    .DEPTH       (`PSPIN_FB_FIFO_DEPTH)
  ) i_fb_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (fb_push),
    .push_data_i (fb_push_data),
    .full_o      (fb_full),
    .valid_o     (nic_feedback_valid_o),
    .data_o      (nic_feedback_o),
    .pop_i       (fb_pop)
  );

  sched_cfg_regs i_cfg_regs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_enable_i (cfg_enable_i),
    .enable_o     (cluster_enable),
    .active_o     (pspin_active_o)
  );

endmodule

/* src/sched_cfg_regs.sv */
// -------------------------------------------------------------------------
// Scheduler configuration registers
// The cluster enable mask resets to all ones and a write takes effect on
// the next cycle. active_o is low in reset, then follows whether any
// cluster is enabled with the same one-cycle timing as the mask.
// -------------------------------------------------------------------------
`timescale 1ns/1ns

module sched_cfg_regs
  import pspin_sched_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,

  input  logic          cfg_we_i,
  input  cluster_mask_t cfg_enable_i,

  output cluster_mask_t enable_o,
  output logic          active_o
);

  cluster_mask_t enable_q, enable_d;
  logic          active_q;

  assign enable_d = cfg_we_i ? cfg_enable_i : enable_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= '1;
      active_q <= 1'b0;
    end else begin
      enable_q <= enable_d;
      // Idle once every cluster is masked off
      active_q <= |enable_d;
    end
  end

  assign enable_o = enable_q;
  assign active_o = active_q;

endmodule

/* tb/tb_clk_gen.sv */
// -------------------------------------------------------------------------
// Clock and reset source for the scheduler testbench
// 8 ns clock starting low. Reset is low from time zero and is released
// on the rising edge that ends the second reset cycle.
// -------------------------------------------------------------------------
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb/tb_pspin_sched.sv */
// -------------------------------------------------------------------------
// Testbench for the packet scheduling path
// Models the clusters and the NIC at the top ports. All DUT inputs change
// by non-blocking assignment right after a rising edge, and all models
// sample on the rising edge, so they see the values of the ending cycle.
// HERs are generated at time zero from one LFSR, with every msgid unique.
// -------------------------------------------------------------------------
`timescale 1ns/1ns
`include "pspin_sched_params.svh"

module tb_pspin_sched
  import pspin_sched_pkg::*;
();

  localparam int NC            = `PSPIN_NUM_CLUSTERS;
  localparam int HPC           = `PSPIN_HERS_PER_CLUSTER;
  localparam int N_HERS        = 200;
  localparam int TB_MAX_CYCLES = N_HERS * 40;
  localparam int STALL_LIMIT   = `PSPIN_HER_FIFO_DEPTH + NC * HPC + 2;
  localparam cluster_mask_t MASK_TWO = 'h3;

  logic                         clk_i;
  logic                         rst_n_i;
  logic                         her_valid_i = 1'b0;
  logic                         her_ready_o;
  her_descr_t                   her_i = '0;
  cluster_mask_t                cluster_task_valid_o;
  handler_task_t                cluster_task_o;
  cluster_mask_t                cluster_feedback_valid_i = '0;
  cluster_mask_t                cluster_feedback_ready_o;
  feedback_descr_t [NC-1:0]     cluster_feedback_i = '0;
  logic                         nic_feedback_valid_o;
  logic                         nic_feedback_ready_i = 1'b0;
  feedback_descr_t              nic_feedback_o;
  logic                         cfg_we_i = 1'b0;
  cluster_mask_t                cfg_enable_i = '1;
  logic                         pspin_active_o;

  logic [31:0]     lfsr_q = 32'h4083cecf;
  her_descr_t      hers [N_HERS];
  her_descr_t      sent_q [$];
  her_descr_t      by_id [int];
  feedback_descr_t pend_fb [NC][$];
  int              pend_due [NC][$];
  int              outstanding [NC];
  int              cycles = 0;
  int              rst_cycles = 0;
  int              post_cycles = 0;
  int              task_cnt = 0;
  int              fb_cnt = 0;
  int              restored_cnt = 0;
  int              mismatch_cnt = 0;
  int              fail_cnt = 0;
  int              phase = 0;
  logic            stall_clusters = 1'b0;
  logic            hold_pending = 1'b0;
  feedback_descr_t held_fb;
  cluster_mask_t   cur_en = '1;
  cluster_mask_t   prev_en = '1;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  pspin_sched_top uut (
    .clk_i                    (clk_i),
    .rst_n_i                  (rst_n_i),
    .her_valid_i              (her_valid_i),
    .her_ready_o              (her_ready_o),
    .her_i                    (her_i),
    .cluster_task_valid_o     (cluster_task_valid_o),
    .cluster_task_o           (cluster_task_o),
    .cluster_feedback_valid_i (cluster_feedback_valid_i),
    .cluster_feedback_ready_o (cluster_feedback_ready_o),
    .cluster_feedback_i       (cluster_feedback_i),
    .nic_feedback_valid_o     (nic_feedback_valid_o),
    .nic_feedback_ready_i     (nic_feedback_ready_i),
    .nic_feedback_o           (nic_feedback_o),
    .cfg_we_i                 (cfg_we_i),
    .cfg_enable_i             (cfg_enable_i),
    .pspin_active_o           (pspin_active_o)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic handler_task_t expected_task(input her_descr_t her, input cluster_idx_t idx);
    handler_task_t t;
    addr_t         base;
    // Step over the L1 windows of the lower clusters
    base = `PSPIN_L1_CLUSTER_BASE;
    for (int c = 0; c < int'(idx); c++) begin
      base = base + `PSPIN_L1_CLUSTER_SPAN;
    end
    t.her_descr  = her;
    t.cluster_id = idx;
    t.l1_base    = base;
    return t;
  endfunction

  function automatic feedback_descr_t expected_feedback(input her_descr_t her);
    feedback_descr_t fb;
    fb.msgid    = her.msgid;
    fb.pkt_addr = her.pkt_addr;
    fb.pkt_size = her.pkt_size;
    return fb;
  endfunction

  task automatic check_task(input handler_task_t got, input handler_task_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch cluster_task_o at %0t: got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_feedback(input feedback_descr_t got, input feedback_descr_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch nic_feedback_o at %0t: got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
    end
  endtask

  // Cluster models, NIC model and scoreboard
  always @(posedge clk_i) begin : models
    cluster_idx_t    idx;
    her_descr_t      her;
    feedback_descr_t fb;
    int              delay;
    cycles++;
    if (!rst_n_i) begin
      rst_cycles++;
      // First edge only sees power-up state
      if (rst_cycles > 1) begin
        check_bit("her_ready_o", her_ready_o, 1'b0);
        check_bit("cluster_task_valid_o", |cluster_task_valid_o, 1'b0);
        check_bit("cluster_feedback_ready_o", |cluster_feedback_ready_o, 1'b0);
        check_bit("nic_feedback_valid_o", nic_feedback_valid_o, 1'b0);
        check_bit("pspin_active_o", pspin_active_o, 1'b0);
      end
      cluster_feedback_valid_i <= '0;
      nic_feedback_ready_i     <= 1'b0;
    end else begin
      if (post_cycles == 0) begin
        check_bit("her_ready_o", her_ready_o, 1'b0);
        check_bit("pspin_active_o", pspin_active_o, 1'b0);
      end else begin
        if (post_cycles == 1) check_bit("her_ready_o", her_ready_o, 1'b1);
        check_bit("pspin_active_o", pspin_active_o, |cur_en);
      end
      post_cycles++;

      if (her_valid_i && her_ready_o) begin
        sent_q.push_back(her_i);
        by_id[int'(her_i.msgid)] = her_i;
      end

      // Task arrival, in HER order
      if (cluster_task_valid_o != '0) begin
        idx = '0;
        for (int c = 0; c < NC; c++) begin
          if (cluster_task_valid_o[c]) idx = cluster_idx_t'(c);
        end
        if (!$onehot(cluster_task_valid_o)) begin
          fail_cnt++;
          $display("Task sent to several clusters at once: %b", cluster_task_valid_o);
        end
        if ((cluster_task_valid_o & ~prev_en) != '0) begin
          fail_cnt++;
          $display("Task sent to disabled cluster %0d at %0t", idx, $time);
        end
        if (sent_q.size() == 0) begin
          fail_cnt++;
          $display("Task seen at %0t with no accepted HER left", $time);
        end else begin
          her = sent_q.pop_front();
          check_task(cluster_task_o, expected_task(her, idx));
          task_cnt++;
        end
        outstanding[idx]++;
        if (outstanding[idx] > HPC) begin
          fail_cnt++;
          $display("Cluster %0d holds %0d tasks, more than its slots", idx, outstanding[idx]);
        end
        if (phase == 2 && !MASK_TWO[idx]) restored_cnt++;
        delay = int'(rand_bits(4));
        if (delay == 0) delay = 1;
        fb.msgid    = cluster_task_o.her_descr.msgid;
        fb.pkt_addr = cluster_task_o.her_descr.pkt_addr;
        fb.pkt_size = cluster_task_o.her_descr.pkt_size;
        pend_fb[idx].push_back(fb);
        pend_due[idx].push_back(cycles + delay);
      end

      // Cluster feedback, held until granted
      for (int c = 0; c < NC; c++) begin
        if (cluster_feedback_valid_i[c] && cluster_feedback_ready_o[c]) begin
          fb    = pend_fb[c].pop_front();
          delay = pend_due[c].pop_front();
          outstanding[c]--;
        end
        if (cluster_feedback_valid_i[c] && !cluster_feedback_ready_o[c]) begin
          cluster_feedback_valid_i[c] <= 1'b1;
        end else if (!stall_clusters && pend_fb[c].size() != 0 && pend_due[c][0] <= cycles) begin
          cluster_feedback_valid_i[c] <= 1'b1;
          cluster_feedback_i[c]       <= pend_fb[c][0];
        end else begin
          cluster_feedback_valid_i[c] <= 1'b0;
        end
      end

      // NIC side
      if (hold_pending) begin
        if (!nic_feedback_valid_o) begin
          fail_cnt++;
          $display("nic_feedback_valid_o dropped at %0t before ready was seen", $time);
        end else begin
          check_feedback(nic_feedback_o, held_fb);
        end
      end
      if (nic_feedback_valid_o && nic_feedback_ready_i) begin
        if (!by_id.exists(int'(nic_feedback_o.msgid))) begin
          fail_cnt++;
          $display("NIC feedback for unknown msgid %h", nic_feedback_o.msgid);
        end else begin
          check_feedback(nic_feedback_o, expected_feedback(by_id[int'(nic_feedback_o.msgid)]));
          by_id.delete(int'(nic_feedback_o.msgid));
          fb_cnt++;
        end
      end
      hold_pending = nic_feedback_valid_o && !nic_feedback_ready_i;
      held_fb      = nic_feedback_o;
      nic_feedback_ready_i <= (rand_bits(2) != '0);

      // Mask in force when the next task was registered
      prev_en = cur_en;
      if (cfg_we_i) cur_en = cfg_enable_i;
    end
  end

  task automatic send_range(input int first, input int last);
    for (int i = first; i <= last; i++) begin
      her_valid_i <= 1'b1;
      her_i       <= hers[i];
      do @(posedge clk_i); while (!her_ready_o);
    end
    her_valid_i <= 1'b0;
  endtask

  task automatic write_mask(input cluster_mask_t mask, input int next_phase);
    @(posedge clk_i);
    cfg_we_i     <= 1'b1;
    cfg_enable_i <= mask;
    phase        <= next_phase;
    @(posedge clk_i);
    cfg_we_i     <= 1'b0;
  endtask

  task automatic wait_feedback(input int count);
    while (fb_cnt < count) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  initial begin : stimulus
    logic [1023:0] used;
    msgid_t        m;
    int            idx;
    int            accepted;
    logic          fell;
    used = '0;
    for (int i = 0; i < N_HERS; i++) begin
      do m = msgid_t'(rand_bits(10)); while (used[m]);
      used[m]              = 1'b1;
      hers[i].msgid        = m;
      hers[i].handler_addr = rand_bits(32);
      hers[i].pkt_addr     = rand_bits(32);
      hers[i].pkt_size     = 16'(rand_bits(16));
    end
    wait (rst_n_i);
    repeat (2) @(posedge clk_i);

    // All clusters, then two masked off, then all restored
    send_range(0, 79);
    write_mask(MASK_TWO, 1);
    send_range(80, 129);
    write_mask('1, 2);
    send_range(130, 169);

    // Stalled clusters must back-pressure the NIC
    wait_feedback(170);
    stall_clusters <= 1'b1;
    idx      = 170;
    accepted = 0;
    fell     = 1'b0;
    her_valid_i <= 1'b1;
    her_i       <= hers[idx];
    while (!fell && accepted <= STALL_LIMIT) begin
      @(posedge clk_i);
      if (her_ready_o) begin
        accepted++;
        idx++;
        her_i <= hers[idx];
      end else begin
        fell = 1'b1;
      end
    end
    if (!fell) begin
      fail_cnt++;
      $display("her_ready_o still high after %0d HERs with clusters stalled", accepted);
    end
    repeat (10) @(posedge clk_i);
    stall_clusters <= 1'b0;
    send_range(idx, N_HERS - 1);

    wait_feedback(N_HERS);
    repeat (4) @(negedge clk_i);
    for (int c = 0; c < NC; c++) begin
      if (outstanding[c] != 0) begin
        fail_cnt++;
        $display("Cluster %0d still holds %0d tasks at the end", c, outstanding[c]);
      end
    end
    if (sent_q.size() != 0 || by_id.num() != 0) begin
      fail_cnt++;
      $display("%0d HERs never reached a cluster or the NIC", by_id.num());
    end
    if (restored_cnt == 0) begin
      fail_cnt++;
      $display("No task reached the re-enabled clusters");
    end
    $display("Checked %0d tasks and %0d feedbacks: %0d mismatches, %0d other errors",
             task_cnt, fb_cnt, mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cycles >= TB_MAX_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TB_MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule
